// File: Makefile
VERILATOR ?= verilator
TOP ?= runnerSprites_tb
FILELIST ?= runnerSprites.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
VFLAGS ?= --binary --assert
RUNFLAGS ?= +verilator+error+limit+1000
PASS_TEXT ?= All tests passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS RUNFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	-./$(BUILD_DIR)/$(TOP) $(RUNFLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_TEXT)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: frameSequencer.sv
`include "runnerSprites_config.svh"

module frameSequencer
	import runnerSprites_pkg::*;
(
	input  logic      frame_Clk,
	input  logic      Reset,
	input  logic      frameTick,
	input  logic      busy,
	input  gameStateT gameState,
	input  logic      dead,
	input  scoreT     score,
	input  coordT     cactusX,
	input  coordT     pteroX,
	output logic      frameStart,
	output frameInfoT frameInfo
);

	localparam int animW = $clog2(`ANIM_FRAMES);

	// spawn window inside every 500 points of score
	localparam scoreT spawnPeriod = 16'd500;
	localparam scoreT spawnLow = 16'd100;
	localparam scoreT spawnHigh = 16'd150;

	// obstacles must be clear of the right half
	localparam coordT cactusLimit = 11'sd320;
	localparam coordT pteroNear = 11'sd320;
	localparam coordT pteroFar = 11'sd670;

	logic tickTaken;
	scoreT scorePhase;
	logic spawnNow;
	logic runNow;
	logic [animW-1:0] animCnt;
	logic animSel;

	// a tick is dropped while the previous frame is still in flight
	assign tickTaken = frameTick && !busy && !frameStart;

	assign scorePhase = score % spawnPeriod;

	assign spawnNow = (scorePhase > spawnLow) && (scorePhase < spawnHigh)
		&& (cactusX < cactusLimit)
		&& ((pteroX < pteroNear) || (pteroX > pteroFar));

	assign runNow = (gameState == running) && !dead;

	// snapshot of the status for the whole frame
	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			frameStart <= 1'b0;
			frameInfo <= '0;
		end
		else
		begin
			frameStart <= tickTaken;
			if (tickTaken)
			begin
				frameInfo.run <= runNow;
				frameInfo.spawnOk <= spawnNow;
				frameInfo.animSel <= animSel;
			end
		end
	end

	// image 1 for the first ANIM_FRAMES frames, then alternate
	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			animCnt <= '0;
			animSel <= 1'b0;
		end
		else if (tickTaken)
		begin
			if (animCnt == animW'(`ANIM_FRAMES - 1))
			begin
				animCnt <= '0;
				animSel <= !animSel;
			end
			else
			begin
				animCnt <= animCnt + 1'b1;
			end
		end
	end

endmodule

// File: heartSprite.sv
`include "runnerSprites_config.svh"

module heartSprite
	import runnerSprites_pkg::*;
(
	input  logic       frame_Clk,
	input  logic       Reset,
	input  logic       frameStart,
	input  frameInfoT  frameInfo,
	input  logic       contact,
	output spriteDescT desc,
	output logic       descValid,
	output coordT      heartPosX,
	output coordT      heartPosY,
	output logic       heartHidden
);

	localparam coordT parkX = coordT'(`SCREEN_W);
	localparam coordT stepX = coordT'(`HEART_SPEED);
	localparam coordT rowY = coordT'(`HEART_Y);

	coordT posX;
	logic contactSeen;
	logic hidden;
	logic imgSel;
	sizeT nextW;
	coordT movedX;
	coordT leaveX;
	logic parked;

	// width of the image this frame is going to show
	assign nextW = frameInfo.animSel ? sizeT'(`HEART2_W) : sizeT'(`HEART1_W);

	assign movedX = posX - stepX;

	// fully past the left edge once posX reaches minus the width
	assign leaveX = -coordT'(nextW);

	assign parked = (posX >= parkX);

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			posX <= parkX;
			contactSeen <= 1'b0;
			hidden <= 1'b0;
			imgSel <= 1'b0;
			descValid <= 1'b0;
		end
		else
		begin
			descValid <= frameStart;

			// contact may arrive in any cycle of the frame
			if (contact)
				contactSeen <= 1'b1;

			if (frameStart)
			begin
				imgSel <= frameInfo.animSel;
				if (contactSeen)
					hidden <= 1'b1;

				if (frameInfo.run)
				begin
					if (parked)
					begin
						// first step off the right edge
						if (frameInfo.spawnOk)
							posX <= movedX;
					end
					else if (movedX <= leaveX)
					begin
						// gone off screen, back to the parking spot
						posX <= parkX;
						contactSeen <= 1'b0;
						hidden <= 1'b0;
					end
					else
					begin
						posX <= movedX;
					end
				end
			end
		end
	end

	// descriptor follows the state written on the frameStart edge
	always_comb
	begin
		desc.posX = posX;
		desc.posY = rowY;
		desc.visible = !hidden && (posX < parkX);
		if (imgSel)
		begin
			desc.base = spriteAddrT'(`HEART2_BASE);
			desc.sizeX = sizeT'(`HEART2_W);
			desc.sizeY = sizeT'(`HEART2_H);
		end
		else
		begin
			desc.base = spriteAddrT'(`HEART1_BASE);
			desc.sizeX = sizeT'(`HEART1_W);
			desc.sizeY = sizeT'(`HEART1_H);
		end
	end

	assign heartPosX = posX;
	assign heartPosY = rowY;
	assign heartHidden = hidden;

endmodule

// File: pixelBlitter.sv
`include "runnerSprites_config.svh"

module pixelBlitter
	import runnerSprites_pkg::*;
(
	input  logic       frame_Clk,
	input  logic       Reset,
	input  logic       descValid,
	input  spriteDescT desc,
	input  logic       creditReturn,
	output pixelWriteT pixWrite,
	output logic       pixValid,
	output logic       busy,
	output logic       frameDone
);

	localparam int creditW = $clog2(`WRITE_CREDITS + 1);
	localparam coordT screenW = coordT'(`SCREEN_W);

	blitStateT state;
	logic [creditW-1:0] credits;
	logic [creditW-1:0] creditNext;
	spriteDescT box;
	sizeT dx;
	sizeT dy;
	sizeT dxFirst;
	sizeT dxLast;
	spriteAddrT rowBase;
	spriteAddrT curAddr;
	coordT colFirst;
	coordT colLimit;
	sizeT firstDx;
	sizeT lastDx;
	logic boxEmpty;
	logic rowEnd;
	logic lastRow;

	// on-screen column range of the incoming descriptor
	always_comb
	begin
		colFirst = (desc.posX < 0) ? -desc.posX : '0;
		if (desc.posX > screenW - coordT'(desc.sizeX))
			colLimit = screenW - desc.posX;
		else
			colLimit = coordT'(desc.sizeX);
		firstDx = sizeT'(colFirst);
		lastDx = sizeT'(colLimit - 1);
		boxEmpty = !desc.visible || (desc.sizeY == '0) || (colFirst >= colLimit);
	end

	assign rowEnd = (dx == dxLast);
	assign lastRow = (dy == box.sizeY - 1'b1);

	// a write goes out only with a credit in hand
	assign pixValid = (state == blitWalk) && (credits != '0);

	assign pixWrite.x = box.posX + coordT'(dx);
	assign pixWrite.y = box.posY + coordT'(dy);
	assign pixWrite.addr = curAddr;

	// descValid counts so no tick slips in before the walk starts
	assign busy = descValid || (state != blitIdle);
	assign frameDone = (state == blitDone);

	// spend and return in the same cycle cancel out
	always_comb
	begin
		creditNext = credits;
		if (pixValid && !creditReturn)
			creditNext = credits - 1'b1;
		else if (!pixValid && creditReturn)
			creditNext = credits + 1'b1;
	end

	always_ff @(posedge frame_Clk or posedge Reset)
	begin
		if (Reset)
		begin
			state <= blitIdle;
			credits <= creditW'(`WRITE_CREDITS);
		end
		else
		begin
			credits <= creditNext;
			case (state)
				blitIdle:
				begin
					if (descValid)
						state <= boxEmpty ? blitDone : blitWalk;
				end
				blitWalk:
				begin
					if (pixValid && rowEnd && lastRow)
						state <= blitDone;
				end
				blitDone:
				begin
					state <= blitIdle;
				end
				default:
				begin
					state <= blitIdle;
				end
			endcase
		end
	end

	// walk position and running address, row-major
	always_ff @(posedge frame_Clk)
	begin
		if ((state == blitIdle) && descValid)
		begin
			box <= desc;
			dxFirst <= firstDx;
			dxLast <= lastDx;
			dx <= firstDx;
			dy <= '0;
			rowBase <= desc.base;
			curAddr <= desc.base + spriteAddrT'(firstDx);
		end
		else if (pixValid)
		begin
			if (rowEnd)
			begin
				// next row starts again at the first unclipped column
				dx <= dxFirst;
				dy <= dy + 1'b1;
				rowBase <= rowBase + spriteAddrT'(box.sizeX);
				curAddr <= rowBase + spriteAddrT'(box.sizeX) + spriteAddrT'(dxFirst);
			end
			else
			begin
				dx <= dx + 1'b1;
				curAddr <= curAddr + 1'b1;
			end
		end
	end

endmodule

// File: runnerSprites.f
+incdir+.
runnerSprites_pkg.sv
frameSequencer.sv
heartSprite.sv
pixelBlitter.sv
runnerSprites.sv
runnerSprites_asserts.sv
runnerSprites_tb.sv

// File: runnerSprites.sv
module runnerSprites
	import runnerSprites_pkg::*;
(
	input  logic       frame_Clk,
	input  logic       Reset,
	input  logic       frameTick,
	input  gameStateT  gameState,
	input  logic       dead,
	input  scoreT      score,
	input  coordT      cactusX,
	input  coordT      pteroX,
	input  logic       contact,
	input  logic       creditReturn,
	output pixelWriteT pixWrite,
	output logic       pixValid,
	output coordT      heartPosX,
	output coordT      heartPosY,
	output logic       heartHidden,
	output logic       frameDone
);

	frameInfoT frameInfo;
	logic frameStart;
	spriteDescT desc;
	logic descValid;
	logic busy;

	// frame boundary and per-frame permissions
	frameSequencer i_frameSequencer
	(
		.frame_Clk  (frame_Clk),
		.Reset      (Reset),
		.frameTick  (frameTick),
		.busy       (busy),
		.gameState  (gameState),
		.dead       (dead),
		.score      (score),
		.cactusX    (cactusX),
		.pteroX     (pteroX),
		.frameStart (frameStart),
		.frameInfo  (frameInfo)
	);

	heartSprite i_heartSprite
	(
		.frame_Clk   (frame_Clk),
		.Reset       (Reset),
		.frameStart  (frameStart),
		.frameInfo   (frameInfo),
		.contact     (contact),
		.desc        (desc),
		.descValid   (descValid),
		.heartPosX   (heartPosX),
		.heartPosY   (heartPosY),
		.heartHidden (heartHidden)
	);

	// pixel writes toward the frame buffer writer
	pixelBlitter i_pixelBlitter
	(
		.frame_Clk    (frame_Clk),
		.Reset        (Reset),
		.descValid    (descValid),
		.desc         (desc),
		.creditReturn (creditReturn),
		.pixWrite     (pixWrite),
		.pixValid     (pixValid),
		.busy         (busy),
		.frameDone    (frameDone)
	);

endmodule

// File: runnerSprites_asserts.sv
`include "runnerSprites_config.svh"

module runnerSprites_asserts
	import runnerSprites_pkg::*;
#(
	parameter int creditW = $clog2(`WRITE_CREDITS + 1)
)
(
	input logic               frame_Clk,
	input logic               Reset,
	input logic [creditW-1:0] credits,
	input logic               creditReturn,
	input logic               pixValid,
	input logic               frameDone
);

	localparam logic [creditW-1:0] maxCredits = creditW'(`WRITE_CREDITS);

	int failCount = 0;

	// each write spends one credit and each return adds one back
	creditTrack: assert property (@(posedge frame_Clk) disable iff (Reset)
		1'b1 |=> (credits == $past(credits) + creditW'($past(creditReturn))
			- creditW'($past(pixValid))))
	else
	begin
		$error("credit count does not follow writes and returns");
		failCount++;
	end

	// an underflow wraps above the pool, so this also catches a write with no credit
	creditCeiling: assert property (@(posedge frame_Clk) disable iff (Reset)
		credits <= maxCredits)
	else
	begin
		$error("credit count above the initial pool");
		failCount++;
	end

	resetQuiet: assert property (@(posedge frame_Clk)
		Reset |-> !pixValid && !frameDone)
	else
	begin
		$error("pixValid or frameDone high during reset");
		failCount++;
	end

endmodule

bind pixelBlitter runnerSprites_asserts i_blitAsserts
(
	.frame_Clk    (frame_Clk),
	.Reset        (Reset),
	.credits      (credits),
	.creditReturn (creditReturn),
	.pixValid     (pixValid),
	.frameDone    (frameDone)
);

// File: runnerSprites_config.svh
`ifndef RUNNERSPRITES_CONFIG_SVH
`define RUNNERSPRITES_CONFIG_SVH

// visible screen area
`define SCREEN_W 640
`define SCREEN_H 480

// the heart travels along a fixed row
`define HEART_Y 256

// pixels per frame, leftward
`define HEART_SPEED 4

// first heart image in sprite memory
`define HEART1_BASE 224411
`define HEART1_W 18
`define HEART1_H 17

// second heart image
`define HEART2_BASE 224717
`define HEART2_W 18
`define HEART2_H 19

// frames shown before switching image
`define ANIM_FRAMES 10

// outstanding writes allowed toward the frame buffer writer
`define WRITE_CREDITS 4

`endif

// File: runnerSprites_pkg.sv
package runnerSprites_pkg;

	// signed so the heart can slide past the left edge
	typedef logic signed [10:0] coordT;
	typedef logic [17:0] spriteAddrT;
	typedef logic [5:0] sizeT;
	typedef logic [15:0] scoreT;

	// same encoding as the game controller
	typedef enum logic [1:0]
	{
		idle    = 2'b00,
		running = 2'b01,
		paused  = 2'b10,
		over    = 2'b11
	} gameStateT;

	typedef enum logic [1:0]
	{
		blitIdle,
		blitWalk,
		blitDone
	} blitStateT;

	// permissions sampled once per frame
	typedef struct packed
	{
		logic run;
		logic spawnOk;
		logic animSel;
	} frameInfoT;

	typedef struct packed
	{
		coordT posX;
		coordT posY;
		spriteAddrT base;
		sizeT sizeX;
		sizeT sizeY;
		logic visible;
	} spriteDescT;

	// one pixel toward the frame buffer writer
	typedef struct packed
	{
		coordT x;
		coordT y;
		spriteAddrT addr;
	} pixelWriteT;

endpackage

// File: runnerSprites_tb.sv
`include "runnerSprites_config.svh"

module runnerSprites_tb
	import runnerSprites_pkg::*;
();

	localparam int frameTimeout = 2000;
	localparam int resetTimeout = 10;

	// one table row drives repeatCnt frames with the same status
	typedef struct packed
	{
		gameStateT gameState;
		logic dead;
		scoreT score;
		coordT cactusX;
		coordT pteroX;
		int contactCyc;
		int repeatCnt;
	} frameRowT;

	logic frame_Clk = 1'b0;
	logic Reset = 1'b1;
	logic frameTick;
	gameStateT gameState;
	logic dead;
	scoreT score;
	coordT cactusX;
	coordT pteroX;
	logic contact;
	logic creditReturn = 1'b0;
	pixelWriteT pixWrite;
	logic pixValid;
	coordT heartPosX;
	coordT heartPosY;
	logic heartHidden;
	logic frameDone;

	frameRowT frameTable[$];
	pixelWriteT expPix[$];
	pixelWriteT gotPix[$];
	int dueTimes[$];
	int cycleNow = 0;
	logic [15:0] lfsr = 16'd47;
	int errorCount = 0;
	int checkCount = 0;

	// reference model state
	int mPosX = `SCREEN_W;
	int mFrame = 0;
	logic mLatch = 1'b0;
	logic mHidden = 1'b0;

	runnerSprites i_runnerSprites
	(
		.frame_Clk    (frame_Clk),
		.Reset        (Reset),
		.frameTick    (frameTick),
		.gameState    (gameState),
		.dead         (dead),
		.score        (score),
		.cactusX      (cactusX),
		.pteroX       (pteroX),
		.contact      (contact),
		.creditReturn (creditReturn),
		.pixWrite     (pixWrite),
		.pixValid     (pixValid),
		.heartPosX    (heartPosX),
		.heartPosY    (heartPosY),
		.heartHidden  (heartHidden),
		.frameDone    (frameDone)
	);

	always #20 frame_Clk = ~frame_Clk;

	initial
	begin
		repeat (4) @(posedge frame_Clk);
		@(negedge frame_Clk);
		Reset = 1'b0;
	end

	function automatic logic [15:0] lfsrNext(input logic [15:0] s);
		if (s[0])
			return (s >> 1) ^ 16'hB400;
		else
			return s >> 1;
	endfunction

	task automatic drawDelay(output int d);
		logic b0;
		logic b1;
		b0 = lfsr[0];
		lfsr = lfsrNext(lfsr);
		b1 = lfsr[0];
		lfsr = lfsrNext(lfsr);
		d = 2 * int'(b1) + int'(b0);
	endtask

	// frame buffer writer: takes every write, returns its credit 0 to 3 cycles later
	always @(negedge frame_Clk)
	begin
		int idx;
		int d;
		cycleNow++;
		idx = -1;
		for (int i = 0; i < dueTimes.size(); i++)
			if (idx < 0 && dueTimes[i] <= cycleNow)
				idx = i;
		if (idx >= 0)
		begin
			dueTimes.delete(idx);
			creditReturn = 1'b1;
		end
		else
			creditReturn = 1'b0;
		if (pixValid)
		begin
			gotPix.push_back(pixWrite);
			drawDelay(d);
			dueTimes.push_back(cycleNow + 1 + d);
		end
	end

	task automatic checkCoord(input string name, input coordT got, input coordT exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic checkAddr(input string name, input spriteAddrT got, input spriteAddrT exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic checkBit(input string name, input logic got, input logic exp);
		checkCount++;
		if (got !== exp)
		begin
			errorCount++;
			$display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic addRow(input gameStateT gs, input logic dn, input int sc, input int cx,
		input int px, input int cc, input int rc);
		frameRowT r;
		r.gameState = gs;
		r.dead = dn;
		r.score = scoreT'(sc);
		r.cactusX = coordT'(cx);
		r.pteroX = coordT'(px);
		r.contactCyc = cc;
		r.repeatCnt = rc;
		frameTable.push_back(r);
	endtask

	task automatic buildTable();
		// parked heart, each spawn condition broken in turn
		addRow(running, 1'b0, 100, 100, 700, -1, 1);
		addRow(running, 1'b0, 150, 100, 700, -1, 1);
		addRow(running, 1'b0, 620, 320, 700, -1, 1);
		addRow(running, 1'b0, 620, 100, 500, -1, 1);
		addRow(paused, 1'b0, 620, 100, 700, -1, 1);
		addRow(running, 1'b1, 620, 100, 700, -1, 1);
		addRow(running, 1'b0, 1120, 100, 100, -1, 1);
		// motion, holds, then off the left edge and park
		addRow(running, 1'b0, 0, 400, 400, -1, 20);
		addRow(paused, 1'b0, 0, 400, 400, -1, 2);
		addRow(over, 1'b0, 0, 400, 400, -1, 1);
		addRow(running, 1'b1, 0, 400, 400, -1, 1);
		addRow(idle, 1'b0, 0, 400, 400, -1, 1);
		addRow(running, 1'b0, 0, 400, 400, -1, 150);
		// respawn, contact mid flight, hidden until parked
		addRow(running, 1'b0, 2620, 100, 680, -1, 1);
		addRow(running, 1'b0, 0, 400, 400, -1, 10);
		addRow(running, 1'b0, 0, 400, 400, 2, 1);
		addRow(running, 1'b0, 0, 400, 400, -1, 5);
		addRow(paused, 1'b0, 0, 400, 400, -1, 2);
		addRow(running, 1'b0, 0, 400, 400, -1, 160);
		addRow(over, 1'b0, 0, 0, 0, -1, 2);
	endtask

	task automatic predictFrame(input frameRowT r);
		int phase;
		logic run;
		logic spawn;
		logic img;
		int w;
		int h;
		int base;
		pixelWriteT p;
		run = (r.gameState == running) && !r.dead;
		phase = int'(r.score) % 500;
		spawn = (phase > 100) && (phase < 150) && (int'(r.cactusX) < 320)
			&& ((int'(r.pteroX) < 320) || (int'(r.pteroX) > 670));
		img = ((mFrame / `ANIM_FRAMES) % 2) != 0;
		mFrame++;
		w = img ? `HEART2_W : `HEART1_W;
		h = img ? `HEART2_H : `HEART1_H;
		base = img ? `HEART2_BASE : `HEART1_BASE;
		if (mLatch)
			mHidden = 1'b1;
		if (run)
		begin
			if (mPosX >= `SCREEN_W)
			begin
				if (spawn)
					mPosX = mPosX - `HEART_SPEED;
			end
			else if (mPosX - `HEART_SPEED <= -w)
			begin
				mPosX = `SCREEN_W;
				mLatch = 1'b0;
				mHidden = 1'b0;
			end
			else
				mPosX = mPosX - `HEART_SPEED;
		end
		expPix.delete();
		if (!mHidden && mPosX < `SCREEN_W)
			for (int dy = 0; dy < h; dy++)
				for (int dx = 0; dx < w; dx++)
					if (mPosX + dx >= 0 && mPosX + dx < `SCREEN_W)
					begin
						p.x = coordT'(mPosX + dx);
						p.y = coordT'(`HEART_Y + dy);
						p.addr = spriteAddrT'(base + dy * w + dx);
						expPix.push_back(p);
					end
	endtask

	task automatic runFrame(input frameRowT r, output logic finished);
		int cyc;
		gotPix.delete();
		contact = 1'b0;
		@(negedge frame_Clk);
		gameState = r.gameState;
		dead = r.dead;
		score = r.score;
		cactusX = r.cactusX;
		pteroX = r.pteroX;
		frameTick = 1'b1;
		cyc = 0;
		finished = 1'b0;
		while (!finished && cyc < frameTimeout)
		begin
			@(negedge frame_Clk);
			cyc++;
			frameTick = 1'b0;
			contact = (cyc == r.contactCyc);
			finished = frameDone;
		end
		contact = 1'b0;
	endtask

	task automatic compareFrame(input int f);
		int n;
		checkCoord($sformatf("heartPosX in frame %0d", f), heartPosX, coordT'(mPosX));
		checkCoord($sformatf("heartPosY in frame %0d", f), heartPosY, coordT'(`HEART_Y));
		checkBit($sformatf("heartHidden in frame %0d", f), heartHidden, mHidden);
		checkCount++;
		if (gotPix.size() != expPix.size())
		begin
			errorCount++;
			$display("frame %0d: %0d pixel writes seen where %0d were expected",
				f, gotPix.size(), expPix.size());
		end
		n = (gotPix.size() < expPix.size()) ? gotPix.size() : expPix.size();
		for (int i = 0; i < n; i++)
		begin
			checkCoord($sformatf("pixWrite.x[%0d] in frame %0d", i, f), gotPix[i].x, expPix[i].x);
			checkCoord($sformatf("pixWrite.y[%0d] in frame %0d", i, f), gotPix[i].y, expPix[i].y);
			checkAddr($sformatf("pixWrite.addr[%0d] in frame %0d", i, f),
				gotPix[i].addr, expPix[i].addr);
		end
	endtask

	initial
	begin
		frameRowT r;
		int frameIdx;
		int waitCnt;
		int assertFails;
		logic finished;
		logic timedOut;
		frameTick = 1'b0;
		gameState = idle;
		dead = 1'b0;
		score = '0;
		cactusX = '0;
		pteroX = '0;
		contact = 1'b0;
		buildTable();
		timedOut = 1'b0;
		frameIdx = 0;
		// outputs while reset is still held
		@(negedge frame_Clk);
		checkBit("pixValid during reset", pixValid, 1'b0);
		checkBit("frameDone during reset", frameDone, 1'b0);
		checkBit("heartHidden during reset", heartHidden, 1'b0);
		checkCoord("heartPosX during reset", heartPosX, coordT'(`SCREEN_W));
		waitCnt = 0;
		while (Reset && waitCnt < resetTimeout)
		begin
			@(negedge frame_Clk);
			waitCnt++;
		end
		if (Reset)
		begin
			$display("reset was not released within %0d cycles", resetTimeout);
			timedOut = 1'b1;
		end
		for (int row = 0; row < frameTable.size() && !timedOut; row++)
		begin
			r = frameTable[row];
			for (int rep = 0; rep < r.repeatCnt && !timedOut; rep++)
			begin
				predictFrame(r);
				runFrame(r, finished);
				if (!finished)
				begin
					$display("frame %0d: frameDone did not arrive within %0d cycles",
						frameIdx, frameTimeout);
					timedOut = 1'b1;
				end
				else
				begin
					compareFrame(frameIdx);
					// contact lands after frameStart, so the heart hides next frame
					if (r.contactCyc >= 0)
						mLatch = 1'b1;
				end
				frameIdx++;
			end
		end
		assertFails = i_runnerSprites.i_pixelBlitter.i_blitAsserts.failCount;
		$display("frames: %0d, checks: %0d, check errors: %0d, assertion errors: %0d",
			frameIdx, checkCount, errorCount, assertFails);
		if (!timedOut && errorCount == 0 && assertFails == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule
